/* sources.f */
+incdir+tb
common/cart_pkg.sv
common/loader_pkg.sv
cart/region_detect.sv
cart/cart_quirks.sv
hdl/cheat_loader.sv
rom/rom_writer.sv
rom/rom_store.sv
hdl/cart_loader_top.sv
tb/tb_cart_loader.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the cart loader testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_cart_loader --Mdir "$BUILD_DIR" -o vsim -f sources.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/vsim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Test completed successfully$" "$LOG"; then
	exit 0
fi
echo "pass line not found in $LOG"
exit 1

/* tb/tb_model.svh */
// testbench reference model
// region choice, quirk and gun lookup, cheat fields and ROM word handling
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// stream words carry the even byte in the low half, the ROM holds them swapped
function automatic logic [15:0] swap_bytes(input logic [15:0] w);
	return {w[7:0], w[15:8]};
endfunction

// byte lane write on top of the old word
function automatic logic [15:0] merge_bytes(input logic [15:0] old, input logic [15:0] wdata,
		input logic [1:0] be);
	logic [15:0] res;
	res = old;
	if (be[0])
		res[7:0] = wdata[7:0];
	if (be[1])
		res[15:8] = wdata[15:8];
	return res;
endfunction

// header letter as {jp, us, eu}
function automatic logic [2:0] letter_class(input logic [7:0] ch);
	if (ch == "J")
		return 3'b100;
	if (ch == "U")
		return 3'b010;
	if (ch >= "0" && ch <= "Z")
		return 3'b001;
	return 3'b000;
endfunction

// first seen region in priority order, else the head of the order
function automatic logic [1:0] expected_region(input logic [1:0] prio, input logic [2:0] jue);
	logic [1:0] order [3];
	case (prio)
		2'd0: order = '{REGION_US, REGION_EU, REGION_JP};
		2'd1: order = '{REGION_EU, REGION_US, REGION_JP};
		2'd2: order = '{REGION_US, REGION_JP, REGION_EU};
		default: order = '{REGION_JP, REGION_US, REGION_EU};
	endcase
	// region r sits at bit 2 - r of jue
	for (int i = 0; i < 3; i++) begin
		if (jue[2 - order[i]])
			return order[i];
	end
	return order[0];
endfunction

// header byte b of a cart whose id starts at 0x183
function automatic logic [7:0] id_byte(input logic [63:0] id, input int b);
	if (b < 'h183 || b > 'h18A)
		return 8'h00;
	return id[63 - 8 * (b - 'h183) -: 8];
endfunction

// only the first matching entry counts
function automatic logic [7:0] expected_quirks(input logic [63:0] id);
	logic [7:0] flags;
	flags = '0;
	for (int i = 0; i < QUIRK_TABLE_SIZE; i++) begin
		if (id == QUIRK_IDS[i]) begin
			flags[QUIRK_BITS[i]] = 1'b1;
			return flags;
		end
	end
	return flags;
endfunction

// {gun type, sensor delay}
function automatic logic [8:0] expected_gun(input logic [63:0] id);
	for (int i = 0; i < GUN_TABLE_SIZE; i++) begin
		if (id == GUN_IDS[i])
			return {GUN_TYPES[i], GUN_DELAYS[i]};
	end
	return {1'b0, GUN_DELAY_DEFAULT};
endfunction

// flags, address, compare, replace; each field is {odd beat, even beat}
function automatic logic [127:0] expected_code(input logic [7:0][15:0] beats);
	return {beats[1], beats[0], beats[3], beats[2], beats[5], beats[4], beats[7], beats[6]};
endfunction

`endif

/* tb/tb_cart_loader.sv */
// testbench for the cartridge loader
// random downloads and ROM port traffic checked against a reference model
`timescale 1ns/1ns
`default_nettype none

module tb_cart_loader
	import cart_pkg::*;
	import loader_pkg::*;
();

	localparam int ROM_ADDR_W    = 12;
	localparam int ACCESS_CYCLES = 4;
	localparam int RESET_CYCLES  = 16;
	localparam int IMAGE_WORDS   = 64;
	localparam int REGION_RUNS   = 12;
	localparam int EXT_RUNS      = 8;
	localparam int QUIRK_RUNS    = 12;
	localparam int CHEAT_RUNS    = 6;
	localparam int PORT1_OPS     = 48;
	// other port in flight then our own access plus drive and sample edges
	localparam int WORST_LAT = 2 * (ACCESS_CYCLES + 1) + 4;
	localparam int TOTAL_OPS = 2 * IMAGE_WORDS + 3 * REGION_RUNS + EXT_RUNS + 6 * QUIRK_RUNS
		+ 8 * CHEAT_RUNS + IMAGE_WORDS + PORT1_OPS + 2 * IMAGE_WORDS;
	localparam int DOWNLOADS = 3 + REGION_RUNS + EXT_RUNS + QUIRK_RUNS;
	localparam int CYCLE_LIMIT = RESET_CYCLES + 2 * (TOTAL_OPS * WORST_LAT + 8 * DOWNLOADS);

	// header letters where half of them count for no region
	localparam logic [7:0] LETTERS [8] = '{"J", "U", "E", "7", " ", "-", "z", "~"};

	logic                  clk_sys;
	logic                  RESET;
	logic                  ioctl_download;
	logic [7:0]            ioctl_index;
	logic                  ioctl_wr;
	logic [DL_ADDR_W-1:0]  ioctl_addr;
	logic [DL_DATA_W-1:0]  ioctl_data;
	logic                  ioctl_wait;
	logic [1:0]            region_mode;
	logic [1:0]            region_priority;
	logic [1:0]            region_req;
	logic                  region_set;
	logic [7:0]            quirk_flags;
	logic                  gun_type;
	logic [7:0]            gun_sensor_delay;
	cheat_code_t           gg_code;
	logic                  gg_valid;
	logic                  gg_reset;
	logic [ROM_ADDR_W-1:0] rom_addr;
	logic [15:0]           rom_wdata;
	logic [1:0]            rom_be;
	logic                  rom_we;
	logic                  rom_req;
	logic [15:0]           rom_rdata;
	logic                  rom_ack;

	int checks = 0;
	int errors = 0;
	int test_checks = 0;
	int test_errors = 0;
	int tests_done = 0;
	int unsigned cycle_count = 0;

	// expected ROM words that count once fully written
	logic [15:0] model_mem [2**ROM_ADDR_W];
	logic        model_known [2**ROM_ADDR_W];

	`include "tb_model.svh"

	cart_loader_top #(
		.ROM_ADDR_W    (ROM_ADDR_W),
		.ACCESS_CYCLES (ACCESS_CYCLES)
	) u_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// run limit
	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == CYCLE_LIMIT) begin
			$display("timeout: run still busy after %0d cycles", CYCLE_LIMIT);
			$display("Test failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// checks and bus tasks
	////////////////////////////////////////////////////////////
	task automatic check_value(input string name, input logic [127:0] expected,
			input logic [127:0] actual);
		checks++;
		test_checks++;
		if (expected !== actual) begin
			errors++;
			test_errors++;
			$display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic finish_test(input string name);
		$display("%s: %0d checks, %0d mismatches", name, test_checks, test_errors);
		tests_done++;
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic begin_download(input logic [7:0] index, input logic [1:0] mode,
			input logic [1:0] prio);
		@(posedge clk_sys);
		ioctl_index <= index;
		region_mode <= mode;
		region_priority <= prio;
		ioctl_download <= 1'b1;
	endtask

	task automatic end_download();
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		// edge detectors see the fall
		repeat (3) @(posedge clk_sys);
	endtask

	// one beat and a hold off while the wait level is up
	task automatic send_beat(input logic [24:0] addr, input logic [15:0] data);
		@(posedge clk_sys);
		ioctl_addr <= addr;
		ioctl_data <= data;
		ioctl_wr <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		if (ioctl_index != CHEAT_INDEX) begin
			model_mem[addr[ROM_ADDR_W:1]] = swap_bytes(data);
			model_known[addr[ROM_ADDR_W:1]] = 1'b1;
		end
		do @(posedge clk_sys); while (ioctl_wait);
	endtask

	// toggle request on port 1 that is done when ack catches up
	task automatic rom_access(input int addr, input logic we, input logic [1:0] be,
			input logic [15:0] wdata);
		@(posedge clk_sys);
		rom_addr <= ROM_ADDR_W'(addr);
		rom_we <= we;
		rom_be <= be;
		rom_wdata <= wdata;
		rom_req <= ~rom_req;
		@(posedge clk_sys);
		while (rom_ack != rom_req)
			@(posedge clk_sys);
	endtask

	task automatic read_check(input int addr, input string name);
		rom_access(addr, 1'b0, 2'b00, 16'h0000);
		check_value(name, model_mem[addr], rom_rdata);
	endtask

	////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////
	task automatic load_and_readback();
		begin_download(8'($urandom_range(0, 254)), 2'd2, 2'd0);
		for (int i = 0; i < IMAGE_WORDS; i++)
			send_beat(25'(2 * i), 16'($urandom));
		end_download();
		for (int i = 0; i < IMAGE_WORDS; i++)
			read_check(i, "rom readback");
		finish_test("rom_load");
	endtask

	task automatic region_by_header();
		logic [3:0][7:0] letters;
		logic [2:0]      seen;
		logic [1:0]      prio;
		for (int run = 0; run < REGION_RUNS; run++) begin
			seen = 3'b000;
			for (int k = 0; k < 4; k++) begin
				// first run has no letters at all and hits the fallback
				letters[k] = (run == 0) ? 8'h20 : LETTERS[$urandom_range(0, 7)];
				seen = seen | letter_class(letters[k]);
			end
			prio = 2'($urandom);
			begin_download(8'($urandom_range(0, 254)), 2'd0, prio);
			send_beat(HDR_REGION_ADDR_A, {letters[1], letters[0]});
			send_beat(HDR_REGION_ADDR_B, {letters[3], letters[2]});
			send_beat(HDR_DONE_ADDR, 16'($urandom));
			check_value("region by header", expected_region(prio, seen), region_req);
			check_value("region set", 1'b1, region_set);
			end_download();
			check_value("region set after download", 1'b0, region_set);
		end
		finish_test("region_header");
	endtask

	task automatic region_by_extension();
		logic [7:0] index;
		for (int run = 0; run < EXT_RUNS; run++) begin
			// extension index carries a region code in its top bits
			index = (run == 0) ? 8'h00 : {2'($urandom_range(0, 2)), 6'($urandom)};
			begin_download(index, 2'd1, 2'($urandom));
			send_beat(HDR_DONE_ADDR, 16'($urandom));
			check_value("region by index", index[7:6], region_req);
			check_value("region set by index", |index, region_set);
			end_download();
		end
		finish_test("region_extension");
	endtask

	task automatic quirk_lookup();
		logic [63:0] id;
		logic [8:0]  gun;
		int          pick;
		for (int run = 0; run < QUIRK_RUNS; run++) begin
			pick = $urandom_range(0, 2);
			if (pick == 0) begin
				id = QUIRK_IDS[$urandom_range(0, QUIRK_TABLE_SIZE - 1)];
			end else if (pick == 1) begin
				id = GUN_IDS[$urandom_range(0, GUN_TABLE_SIZE - 1)];
			end else begin
				for (int c = 0; c < 8; c++)
					id[8 * c +: 8] = 8'($urandom_range(33, 126));
			end
			begin_download(8'($urandom_range(0, 254)), 2'd2, 2'd0);
			for (int a = 'h182; a <= 'h18A; a += 2)
				send_beat(25'(a), {id_byte(id, a + 1), id_byte(id, a)});
			send_beat(QUIRK_EVAL_ADDR, 16'($urandom));
			gun = expected_gun(id);
			check_value("quirk flags", expected_quirks(id), quirk_flags);
			check_value("gun type", gun[8], gun_type);
			check_value("gun sensor delay", gun[7:0], gun_sensor_delay);
			end_download();
		end
		finish_test("quirk_lookup");
	endtask

	task automatic cheat_codes();
		logic [7:0][15:0] beats;
		logic [127:0]     code;
		logic [24:0]      addr;
		begin_download(CHEAT_INDEX, 2'd2, 2'd0);
		for (int run = 0; run < CHEAT_RUNS; run++) begin
			for (int k = 0; k < 8; k++) begin
				beats[k] = 16'($urandom);
				addr = 25'(16 * run + 2 * k);
				send_beat(addr, beats[k]);
				// pulses show one cycle after the beat
				check_value("cheat valid", k == 7, gg_valid);
				check_value("cheat reset", run == 0 && k == 0, gg_reset);
			end
			code = expected_code(beats);
			check_value("cheat flags", code[127:96], gg_code.field[3]);
			check_value("cheat address", code[95:64], gg_code.field[2]);
			check_value("cheat compare", code[63:32], gg_code.field[1]);
			check_value("cheat replace", code[31:0], gg_code.field[0]);
		end
		end_download();
		finish_test("cheat_codes");
	endtask

	// port 1 works in words 128..191 while the download fills 64..127
	task automatic arbiter_contention();
		logic [15:0] dl_data [IMAGE_WORDS];
		for (int i = 0; i < IMAGE_WORDS; i++)
			dl_data[i] = 16'($urandom);
		begin_download(8'($urandom_range(0, 254)), 2'd2, 2'd0);
		fork
			for (int i = 0; i < IMAGE_WORDS; i++)
				send_beat(25'(2 * (IMAGE_WORDS + i)), dl_data[i]);
			for (int n = 0; n < PORT1_OPS; n++)
				port1_random_op();
		join
		end_download();
		for (int a = IMAGE_WORDS; a < 3 * IMAGE_WORDS; a++) begin
			if (model_known[a])
				read_check(a, "final memory");
		end
		finish_test("arbiter_contention");
	endtask

	task automatic port1_random_op();
		int          a;
		logic [1:0]  be;
		logic [15:0] wd;
		a = 2 * IMAGE_WORDS + $urandom_range(0, IMAGE_WORDS - 1);
		if (model_known[a] && $urandom_range(0, 1) == 1) begin
			read_check(a, "port 1 read");
		end else begin
			// a fresh word is written whole and later writes may pick lanes
			be = model_known[a] ? 2'($urandom_range(1, 3)) : 2'b11;
			wd = 16'($urandom);
			rom_access(a, 1'b1, be, wd);
			model_mem[a] = merge_bytes(model_mem[a], wd, be);
			model_known[a] = 1'b1;
		end
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////
	initial begin
		RESET = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index = '0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_data = '0;
		region_mode = 2'd2;
		region_priority = '0;
		rom_addr = '0;
		rom_wdata = '0;
		rom_be = '0;
		rom_we = 1'b0;
		rom_req = 1'b0;
		for (int a = 0; a < 2**ROM_ADDR_W; a++)
			model_known[a] = 1'b0;
		void'($urandom(32'ha7f8));
		repeat (RESET_CYCLES) @(posedge clk_sys);
		RESET <= 1'b0;
		@(posedge clk_sys);
		check_value("wait after reset", 1'b0, ioctl_wait);
		check_value("region after reset", REGION_JP, region_req);
		check_value("region set after reset", 1'b0, region_set);
		check_value("quirks after reset", 8'h00, quirk_flags);
		check_value("gun type after reset", 1'b0, gun_type);
		check_value("gun delay after reset", GUN_DELAY_DEFAULT, gun_sensor_delay);
		check_value("cheat valid after reset", 1'b0, gg_valid);
		check_value("cheat reset after reset", 1'b0, gg_reset);
		check_value("rom ack after reset", rom_req, rom_ack);
		finish_test("reset_values");
		load_and_readback();
		region_by_header();
		region_by_extension();
		quirk_lookup();
		cheat_codes();
		arbiter_contention();
		$display("tests %0d, checks %0d, mismatches %0d", tests_done, checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/cart_loader_top.sv */
// cartridge loader top
// splits the download by kind and wires region, quirk, cheat and ROM blocks
`timescale 1ns/1ns
`default_nettype none

module cart_loader_top
	import loader_pkg::*;
#(
	parameter int ROM_ADDR_W    = 12,
	parameter int ACCESS_CYCLES = 4
) (
	input  logic                  clk_sys,
	input  logic                  RESET,
	// download stream
	input  logic                  ioctl_download,
	input  logic [7:0]            ioctl_index,
	input  logic                  ioctl_wr,
	input  logic [DL_ADDR_W-1:0]  ioctl_addr,
	input  logic [DL_DATA_W-1:0]  ioctl_data,
	output logic                  ioctl_wait,
	// region control
	input  logic [1:0]            region_mode,
	input  logic [1:0]            region_priority,
	output logic [1:0]            region_req,
	output logic                  region_set,
	// per-game settings
	output logic [7:0]            quirk_flags,
	output logic                  gun_type,
	output logic [7:0]            gun_sensor_delay,
	// cheat codes
	output cheat_code_t           gg_code,
	output logic                  gg_valid,
	output logic                  gg_reset,
	// system side ROM port
	input  logic [ROM_ADDR_W-1:0] rom_addr,
	input  logic [ROM_DATA_W-1:0] rom_wdata,
	input  logic [ROM_BE_W-1:0]   rom_be,
	input  logic                  rom_we,
	input  logic                  rom_req,
	output logic [ROM_DATA_W-1:0] rom_rdata,
	output logic                  rom_ack
);

	// cheat files come in on their own menu index
	logic cart_download;
	logic code_download;

	// download writer to store port 0
	logic [ROM_WORD_ADDR_W-1:0] wr_addr;
	logic [ROM_DATA_W-1:0]      wr_data;
	logic                       wr_req;
	logic                       wr_ack;

	assign cart_download = ioctl_download && (ioctl_index != CHEAT_INDEX);
	assign code_download = ioctl_download && (ioctl_index == CHEAT_INDEX);

	region_detect u_region (.*);

	cart_quirks u_quirks (.*);

	cheat_loader u_cheat (.*);

	rom_writer u_writer (.*);

	rom_store #(
		.ROM_ADDR_W    (ROM_ADDR_W),
		.ACCESS_CYCLES (ACCESS_CYCLES)
	) u_store (.*);

endmodule

`default_nettype wire

/* rom/rom_store.sv */
// two-port ROM store with byte lanes and a round robin arbiter
// port 0 is the download writer, port 1 the system side
`timescale 1ns/1ns
`default_nettype none

module rom_store
	import loader_pkg::*;
#(
	parameter int ROM_ADDR_W    = 12,
	parameter int ACCESS_CYCLES = 4
) (
	input  logic                       clk_sys,
	input  logic                       RESET,
	// port 0, full word writes
	input  logic [ROM_WORD_ADDR_W-1:0] wr_addr,
	input  logic [ROM_DATA_W-1:0]      wr_data,
	input  logic                       wr_req,
	output logic                       wr_ack,
	// port 1, reads or byte lane writes
	input  logic [ROM_ADDR_W-1:0]      rom_addr,
	input  logic [ROM_DATA_W-1:0]      rom_wdata,
	input  logic [ROM_BE_W-1:0]        rom_be,
	input  logic                       rom_we,
	input  logic                       rom_req,
	output logic [ROM_DATA_W-1:0]      rom_rdata,
	output logic                       rom_ack
);

	localparam int CNT_W = (ACCESS_CYCLES > 1) ? $clog2(ACCESS_CYCLES) : 1;

	logic [ROM_BE_W-1:0][7:0] mem [2**ROM_ADDR_W];

	// request pending while req and ack differ
	logic pend0;
	logic pend1;
	logic [1:0] grant;
	// one access in flight; cur_port also marks the last port served
	logic busy;
	logic cur_port;
	logic [CNT_W-1:0] cnt;
	logic done;

	assign pend0 = wr_req ^ wr_ack;
	assign pend1 = rom_req ^ rom_ack;
	assign done = busy && (cnt == '0);

	// round robin: on contention the port not served last goes first
	always_comb begin
		grant = 2'b00;
		if (!busy) begin
			if (pend0 && pend1)
				grant = cur_port ? 2'b01 : 2'b10;
			else
				grant = {pend1, pend0};
		end
	end

	////////////////////////////////////////////////////////////
	// arbiter and access timer
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			busy <= 1'b0;
			cur_port <= 1'b1;
			cnt <= '0;
			wr_ack <= 1'b0;
			rom_ack <= 1'b0;
		end else if (!busy) begin
			if (|grant) begin
				busy <= 1'b1;
				cur_port <= grant[1];
				cnt <= CNT_W'(ACCESS_CYCLES - 1);
			end
		end else if (!done) begin
			cnt <= cnt - 1'b1;
		end else begin
			// ack toggle closes the access
			busy <= 1'b0;
			if (cur_port)
				rom_ack <= ~rom_ack;
			else
				wr_ack <= ~wr_ack;
		end
	end

	// requesters hold address and data while pending
	always_ff @(posedge clk_sys) begin
		if (done) begin
			if (!cur_port) begin
				mem[wr_addr[ROM_ADDR_W-1:0]] <= wr_data;
			end else if (rom_we) begin
				for (int b = 0; b < ROM_BE_W; b++) begin
					if (rom_be[b])
						mem[rom_addr][b] <= rom_wdata[8*b +: 8];
				end
			end else begin
				rom_rdata <= mem[rom_addr];
			end
		end
	end

	// an access in flight always belongs to a pending request
	a_grant_pending: assert property (@(posedge clk_sys) disable iff (RESET)
		busy |-> (cur_port ? pend1 : pend0));

endmodule

`default_nettype wire

/* rom/rom_writer.sv */
// cart download writer, one toggle request per beat into ROM port 0
// holds the stream off with the wait level until the store acks
`timescale 1ns/1ns
`default_nettype none

module rom_writer
	import loader_pkg::*;
(
	input  logic                       clk_sys,
	input  logic                       RESET,
	input  logic                       cart_download,
	input  logic                       ioctl_wr,
	input  logic [DL_ADDR_W-1:0]       ioctl_addr,
	input  logic [DL_DATA_W-1:0]       ioctl_data,
	input  logic                       wr_ack,
	output logic [ROM_WORD_ADDR_W-1:0] wr_addr,
	output logic [ROM_DATA_W-1:0]      wr_data,
	output logic                       wr_req,
	output logic                       ioctl_wait
);

	// word address and swapped data stay put until the next beat
	always_ff @(posedge clk_sys) begin
		if (cart_download && ioctl_wr) begin
			wr_addr <= ioctl_addr[DL_ADDR_W-1:1];
			wr_data <= {ioctl_data[7:0], ioctl_data[15:8]};
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			wr_req <= 1'b0;
			ioctl_wait <= 1'b0;
		end else if (cart_download && ioctl_wr) begin
			wr_req <= ~wr_req;
			ioctl_wait <= 1'b1;
		end else if (ioctl_wait && (wr_req == wr_ack)) begin
			// store has taken the word
			ioctl_wait <= 1'b0;
		end
	end

	// source must respect the wait level
	a_no_beat_in_wait: assert property (@(posedge clk_sys) disable iff (RESET)
		ioctl_wait |-> !(cart_download && ioctl_wr));

endmodule

`default_nettype wire

/* hdl/cheat_loader.sv */
// cheat code assembly from the 16-bit cheat download beats
`timescale 1ns/1ns
`default_nettype none

module cheat_loader
	import loader_pkg::*;
(
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  logic                 code_download,
	input  logic                 ioctl_wr,
	input  logic [DL_ADDR_W-1:0] ioctl_addr,
	input  logic [DL_DATA_W-1:0] ioctl_data,
	output cheat_code_t          gg_code,
	output logic                 gg_valid,
	output logic                 gg_reset
);

	// beat k of each 16-byte code goes to slot[3 - k/2][k%2]
	always_ff @(posedge clk_sys) begin
		if (code_download && ioctl_wr)
			gg_code.slot[2'd3 - ioctl_addr[3:2]][ioctl_addr[1]] <= ioctl_data;
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			gg_valid <= 1'b0;
			gg_reset <= 1'b0;
		end else begin
			// replace top word completes a code
			gg_valid <= code_download && ioctl_wr && (ioctl_addr[3:0] == 4'd14);
			// first beat of the file flushes the old list
			gg_reset <= code_download && ioctl_wr && (ioctl_addr == '0);
		end
	end

endmodule

`default_nettype wire

/* cart/cart_quirks.sv */
// cart id capture from the header and per-game quirk and lightgun lookup
`timescale 1ns/1ns
`default_nettype none

module cart_quirks
	import cart_pkg::*;
	import loader_pkg::*;
(
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  logic                 cart_download,
	input  logic                 ioctl_wr,
	input  logic [DL_ADDR_W-1:0] ioctl_addr,
	input  logic [DL_DATA_W-1:0] ioctl_data,
	output logic [7:0]           quirk_flags,
	output logic                 gun_type,
	output logic [7:0]           gun_sensor_delay
);

	// 8 ascii bytes, first character in the top byte
	logic [63:0] cart_id;
	logic        old_download;

	// one-hot mask of the first matching quirk entry
	function automatic logic [7:0] quirk_mask(input logic [63:0] id);
		logic [7:0] mask;
		logic       found;
		mask = '0;
		found = 1'b0;
		for (int i = 0; i < QUIRK_TABLE_SIZE; i++) begin
			if (!found && id == QUIRK_IDS[i]) begin
				mask[QUIRK_BITS[i]] = 1'b1;
				found = 1'b1;
			end
		end
		return mask;
	endfunction

	// {gun type, sensor delay}, default when no entry matches
	function automatic logic [8:0] gun_lookup(input logic [63:0] id);
		logic [8:0] res;
		logic       found;
		res = {1'b0, GUN_DELAY_DEFAULT};
		found = 1'b0;
		for (int i = 0; i < GUN_TABLE_SIZE; i++) begin
			if (!found && id == GUN_IDS[i]) begin
				res = {GUN_TYPES[i], GUN_DELAYS[i]};
				found = 1'b1;
			end
		end
		return res;
	endfunction

	////////////////////////////////////////////////////////////
	// id capture, stream words are byte swapped
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (cart_download && ioctl_wr) begin
			if (ioctl_addr == CART_ID_ADDR_FIRST)
				cart_id[63:56] <= ioctl_data[15:8];
			if (ioctl_addr == CART_ID_ADDR_FIRST + 25'd2)
				cart_id[55:40] <= {ioctl_data[7:0], ioctl_data[15:8]};
			if (ioctl_addr == CART_ID_ADDR_FIRST + 25'd4)
				cart_id[39:24] <= {ioctl_data[7:0], ioctl_data[15:8]};
			if (ioctl_addr == CART_ID_ADDR_FIRST + 25'd6)
				cart_id[23:8] <= {ioctl_data[7:0], ioctl_data[15:8]};
			if (ioctl_addr == CART_ID_ADDR_LAST)
				cart_id[7:0] <= ioctl_data[7:0];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_download <= 1'b0;
			quirk_flags <= '0;
			gun_type <= 1'b0;
			gun_sensor_delay <= GUN_DELAY_DEFAULT;
		end else begin
			old_download <= cart_download;
			if (cart_download && !old_download)
				quirk_flags <= '0;
			// id is complete by the eval beat
			if (cart_download && ioctl_wr && ioctl_addr == QUIRK_EVAL_ADDR) begin
				quirk_flags <= quirk_flags | quirk_mask(cart_id);
				{gun_type, gun_sensor_delay} <= gun_lookup(cart_id);
			end
		end
	end

	// one game never carries two quirks
	a_one_quirk: assert property (@(posedge clk_sys) disable iff (RESET)
		$onehot0(quirk_flags & ~$past(quirk_flags)));

endmodule

`default_nettype wire

/* cart/region_detect.sv */
// header region scan, picks the console region from the header letters
// or from the file-extension menu index
`timescale 1ns/1ns
`default_nettype none

module region_detect
	import cart_pkg::*;
	import loader_pkg::*;
(
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  logic                 cart_download,
	input  logic                 ioctl_wr,
	input  logic [DL_ADDR_W-1:0] ioctl_addr,
	input  logic [DL_DATA_W-1:0] ioctl_data,
	input  logic [7:0]           ioctl_index,
	input  logic [1:0]           region_mode,
	input  logic [1:0]           region_priority,
	output logic [1:0]           region_req,
	output logic                 region_set
);

	logic old_download;
	logic hdr_j, hdr_u, hdr_e;
	// header complete flag and its delayed copy for edge detect
	logic hdr_ready;
	logic old_ready;

	// maps one header character to {j, u, e} where anything else from 0 to Z is EU
	function automatic logic [2:0] classify(input logic [7:0] ch);
		if (ch == "J")
			return 3'b100;
		else if (ch == "U")
			return 3'b010;
		else if (ch >= "0" && ch <= "Z")
			return 3'b001;
		return 3'b000;
	endfunction

	// pick by priority order with the head of the order as fallback
	function automatic logic [1:0] pick_region(input logic [1:0] prio,
			input logic j, input logic u, input logic e);
		case (prio)
			2'd0: return u ? REGION_US : e ? REGION_EU : j ? REGION_JP : REGION_US;
			2'd1: return e ? REGION_EU : u ? REGION_US : j ? REGION_JP : REGION_EU;
			2'd2: return u ? REGION_US : j ? REGION_JP : e ? REGION_EU : REGION_US;
			default: return j ? REGION_JP : u ? REGION_US : e ? REGION_EU : REGION_JP;
		endcase
	endfunction

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_download <= 1'b0;
			{hdr_j, hdr_u, hdr_e} <= 3'b000;
			hdr_ready <= 1'b0;
			old_ready <= 1'b0;
			region_set <= 1'b0;
			region_req <= REGION_JP;
		end else begin
			old_download <= cart_download;
			old_ready <= hdr_ready;

			// a new cart forgets the old letters
			if (cart_download && !old_download)
				{hdr_j, hdr_u, hdr_e} <= 3'b000;
			if (!cart_download && old_download)
				hdr_ready <= 1'b0;

			if (cart_download && ioctl_wr) begin
				// both bytes of both region words carry letters
				if (ioctl_addr == HDR_REGION_ADDR_A || ioctl_addr == HDR_REGION_ADDR_B)
					{hdr_j, hdr_u, hdr_e} <= {hdr_j, hdr_u, hdr_e}
						| classify(ioctl_data[7:0]) | classify(ioctl_data[15:8]);
				if (ioctl_addr == HDR_DONE_ADDR)
					hdr_ready <= 1'b1;
			end

			// decide once per header while mode 2 and up leave the region alone
			if (hdr_ready && !old_ready) begin
				case (region_mode)
					2'd0: begin
						region_set <= 1'b1;
						region_req <= pick_region(region_priority, hdr_j, hdr_u, hdr_e);
					end
					2'd1: begin
						region_set <= |ioctl_index;
						region_req <= ioctl_index[7:6];
					end
					default: ;
				endcase
			end

			// drop the request once the download has ended
			if (old_ready && !hdr_ready)
				region_set <= 1'b0;
		end
	end

	// the unused code never reaches the system side
	a_region_code: assert property (@(posedge clk_sys) disable iff (RESET)
		region_req != 2'd3);

endmodule

`default_nettype wire

/* common/loader_pkg.sv */
// download stream and ROM store widths, plus the cheat code word
// shared by the loader blocks
`default_nettype none

package loader_pkg;

	////////////////////////////////////////////////////////////
	// download stream
	////////////////////////////////////////////////////////////
	localparam int DL_ADDR_W = 25;
	localparam int DL_DATA_W = 16;

	// menu index reserved for cheat code files
	localparam logic [7:0] CHEAT_INDEX = 8'hFF;

	////////////////////////////////////////////////////////////
	// ROM store
	////////////////////////////////////////////////////////////
	// word address drops the byte bit of the stream address
	localparam int ROM_WORD_ADDR_W = DL_ADDR_W - 1;
	localparam int ROM_DATA_W      = 16;
	localparam int ROM_BE_W        = ROM_DATA_W / 8;

	// 128-bit cheat code
	// slot view: slot[f][h] is half h (0 = bottom, 1 = top) of field f,
	// download slot k lands in slot[3 - k/2][k%2]
	// field view: field[3] flags, field[2] address,
	// field[1] compare, field[0] replace
	// values arrive big endian, the consumer reorders them
	typedef union packed {
		logic [3:0][1:0][15:0] slot;
		logic [3:0][31:0]      field;
	} cheat_code_t;

endpackage

`default_nettype wire

/* common/cart_pkg.sv */
// cartridge header layout, console region codes and per-game quirk tables
// used by the header scan and the quirk lookup
`default_nettype none

package cart_pkg;

	////////////////////////////////////////////////////////////
	// header byte addresses on the download stream
	////////////////////////////////////////////////////////////
	localparam logic [24:0] HDR_REGION_ADDR_A  = 25'h1F0;
	localparam logic [24:0] HDR_REGION_ADDR_B  = 25'h1F2;
	localparam logic [24:0] HDR_DONE_ADDR      = 25'h200;
	// 8-byte cart id spans five beats
	localparam logic [24:0] CART_ID_ADDR_FIRST = 25'h182;
	localparam logic [24:0] CART_ID_ADDR_LAST  = 25'h18A;
	localparam logic [24:0] QUIRK_EVAL_ADDR    = 25'h18C;

	// console region codes
	localparam logic [1:0] REGION_JP = 2'd0;
	localparam logic [1:0] REGION_US = 2'd1;
	localparam logic [1:0] REGION_EU = 2'd2;

	// bit positions in the quirk vector
	localparam int QUIRK_SRAM   = 0;
	localparam int QUIRK_EEPROM = 1;
	localparam int QUIRK_NORAM  = 2;
	localparam int QUIRK_FIFO   = 3;
	localparam int QUIRK_PIER   = 4;
	localparam int QUIRK_SVP    = 5;
	localparam int QUIRK_FMBUSY = 6;
	localparam int QUIRK_SCHAN  = 7;

	// lightgun sensor delay when the cart is not in the gun table
	localparam logic [7:0] GUN_DELAY_DEFAULT = 8'd44;

	////////////////////////////////////////////////////////////
	// quirk table, first match wins
	////////////////////////////////////////////////////////////
	localparam int QUIRK_TABLE_SIZE = 10;
	localparam logic [63:0] QUIRK_IDS [QUIRK_TABLE_SIZE] = '{
		"T-081276", "T-81406 ", "MK-1215 ", "G-4060  ", "T-113016",
		"T-89016 ", "T-574023", "MK-1229 ", "T-35036 ", "T-68???-"
	};
	localparam int QUIRK_BITS [QUIRK_TABLE_SIZE] = '{
		QUIRK_SRAM, QUIRK_SRAM, QUIRK_EEPROM, QUIRK_EEPROM, QUIRK_NORAM,
		QUIRK_FIFO, QUIRK_PIER, QUIRK_SVP, QUIRK_FMBUSY, QUIRK_SCHAN
	};

	// gun table: type 1 is the justifier style gun
	localparam int GUN_TABLE_SIZE = 5;
	localparam logic [63:0] GUN_IDS [GUN_TABLE_SIZE] = '{
		"MK-1533 ", "T-95096-", "T-95136-", "MK-1658 ", "T-081156"
	};
	localparam logic GUN_TYPES [GUN_TABLE_SIZE] = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b0};
	localparam logic [7:0] GUN_DELAYS [GUN_TABLE_SIZE] = '{
		8'd100, 8'd52, 8'd30, 8'd120, 8'd126
	};

endpackage

`default_nettype wire
